// ==== backend_pkg.sv ====
`default_nettype none

package backend_pkg;

    localparam int XLEN = 32;
    localparam int HALF = XLEN / 2;       // multiplier split point
    localparam int NREG = 32;
    localparam int RAW = $clog2(NREG);    // register index width
    localparam int NPIPE = 2;
    localparam int NSTAGE = 3;            // ex, m1, m2
    localparam int MUL_READY_STAGE = 2;   // product forwardable from m2 on
    localparam int IMMW = 18;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [RAW-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_MUL  = 4'h7
    } opcode_e;

    // register-register view
    typedef struct packed {
        opcode_e     opcode;   // 31..28
        reg_idx_t    rd;       // 27..23
        reg_idx_t    rs1;      // 22..18
        reg_idx_t    rs2;      // 17..13
        logic [12:0] unused;
    } r_fmt_t;

    // register-immediate view
    typedef struct packed {
        opcode_e         opcode;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        logic [IMMW-1:0] imm;  // signed
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        word_t  raw;
    } inst_word_u;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_rs2;
        word_t    imm;         // already sign extended
        logic     is_mul;
    } decode_info_t;

    // one frontend slot
    typedef struct packed {
        word_t      pc;
        inst_word_u word;
    } inst_t;

    typedef struct packed {
        logic [2:0] src;       // one-hot over pipe 0, pipe 1 and reg file
        logic [1:0] stage;     // ex, m1, m2 when a pipe is selected
    } fwd_sel_t;

    localparam fwd_sel_t FWD_RF = '{src: 3'b100, stage: 2'd0};

    typedef struct packed {
        logic         valid;
        logic         older;   // set for the older half of a pair or a single issue
        word_t        pc;
        decode_info_t info;
        word_t        op_a;
        word_t        op_b;
        word_t        result;
    } stage_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t w_reg;
        word_t    w_data;
    } commit_t;

endpackage

`default_nettype wire

// ==== decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  backend_pkg::inst_word_u   inst_word_i,
    input  logic                      inst_valid_i,
    output backend_pkg::decode_info_t decode_o
);

    backend_pkg::opcode_e opcode;
    backend_pkg::word_t   imm_ext;

    assign opcode = inst_word_i.r.opcode;  // same bits in both views

    assign imm_ext = {{(backend_pkg::XLEN - backend_pkg::IMMW){
                          inst_word_i.i.imm[backend_pkg::IMMW-1]}},
                      inst_word_i.i.imm};

    always_comb begin
        decode_o = '0;  // nop writing r0
        if (inst_valid_i) begin
            case (opcode)
                backend_pkg::OP_ADD,
                backend_pkg::OP_SUB,
                backend_pkg::OP_AND,
                backend_pkg::OP_OR,
                backend_pkg::OP_XOR,
                backend_pkg::OP_MUL: begin
                    decode_o.opcode  = opcode;
                    decode_o.rd      = inst_word_i.r.rd;
                    decode_o.rs1     = inst_word_i.r.rs1;
                    decode_o.rs2     = inst_word_i.r.rs2;
                    decode_o.use_rs2 = 1'b1;
                    decode_o.is_mul  = (opcode == backend_pkg::OP_MUL);
                end
                backend_pkg::OP_ADDI: begin
                    // rs2 stays r0 so it never looks like a dependence
                    decode_o.opcode = opcode;
                    decode_o.rd     = inst_word_i.i.rd;
                    decode_o.rs1    = inst_word_i.i.rs1;
                    decode_o.imm    = imm_ext;
                end
                default: begin
                    decode_o = '0;  // unknown opcode
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue (
    input  backend_pkg::decode_info_t [1:0] decode_i,
    input  logic [1:0]                      inst_valid_i,
    input  backend_pkg::stage_t [backend_pkg::NPIPE-1:0][backend_pkg::NSTAGE-1:0] stage_i,
    output logic [1:0]                      issue_o,     // 00, 01 or 11
    output logic                            revert_o,    // slot 1 goes to pipe 0
    output backend_pkg::fwd_sel_t [backend_pkg::NPIPE-1:0][1:0] fwd_sel_o
);

    logic [1:0] mul_wait;  // slot needs a product that is not out yet
    logic       pair_dep;
    logic       both_mul;

    function automatic logic reads(input backend_pkg::decode_info_t d,
                                   input backend_pkg::reg_idx_t r);
        return (r != '0) && (d.rs1 == r || (d.use_rs2 && d.rs2 == r));
    endfunction

    function automatic logic mul_busy(input backend_pkg::decode_info_t d);
        logic busy;
        busy = 1'b0;
        for (int q = 0; q < backend_pkg::NPIPE; q++) begin
            for (int s = 0; s < backend_pkg::MUL_READY_STAGE; s++) begin
                if (stage_i[q][s].valid && stage_i[q][s].info.is_mul &&
                    reads(d, stage_i[q][s].info.rd)) begin
                    busy = 1'b1;
                end
            end
        end
        return busy;
    endfunction

    // youngest producer of src, or the reg file
    function automatic backend_pkg::fwd_sel_t pick(input backend_pkg::reg_idx_t src);
        backend_pkg::fwd_sel_t sel;
        sel = backend_pkg::FWD_RF;
        if (src != '0) begin
            // walk from m2 to ex, older half first, so later hits win
            for (int s = backend_pkg::NSTAGE - 1; s >= 0; s--) begin
                for (int o = 1; o >= 0; o--) begin
                    for (int q = 0; q < backend_pkg::NPIPE; q++) begin
                        if (stage_i[q][s].valid && stage_i[q][s].older == o[0] &&
                            stage_i[q][s].info.rd == src) begin
                            sel.src   = 3'(1 << q);
                            sel.stage = 2'(s);
                        end
                    end
                end
            end
        end
        return sel;
    endfunction

    always_comb begin
        mul_wait[0] = mul_busy(decode_i[0]);
        mul_wait[1] = mul_busy(decode_i[1]);
        pair_dep    = reads(decode_i[1], decode_i[0].rd);
        both_mul    = decode_i[0].is_mul && decode_i[1].is_mul;

        issue_o[0] = inst_valid_i[0] && !mul_wait[0];
        issue_o[1] = issue_o[0] && inst_valid_i[1] && !mul_wait[1] &&
                     !pair_dep && !both_mul;

        revert_o = issue_o[1] && decode_i[1].is_mul;  // multiplier lives in pipe 0
    end

    always_comb begin
        logic slot;
        for (int p = 0; p < backend_pkg::NPIPE; p++) begin
            slot = (p != 0) ^ revert_o;
            fwd_sel_o[p][0] = pick(decode_i[slot].rs1);
            fwd_sel_o[p][1] = pick(decode_i[slot].use_rs2 ? decode_i[slot].rs2 : '0);
        end
    end

    // an issued operand never takes a multiply result before it is ready
    always_comb begin
        logic                  slot;
        backend_pkg::fwd_sel_t sel;
        for (int p = 0; p < backend_pkg::NPIPE; p++) begin
            slot = (p != 0) ^ revert_o;
            for (int k = 0; k < 2; k++) begin
                sel = fwd_sel_o[p][k];
                for (int q = 0; q < backend_pkg::NPIPE; q++) begin
                    if (issue_o[slot] && sel.src[q] &&
                        int'(sel.stage) < backend_pkg::MUL_READY_STAGE) begin
                        assert (!(stage_i[q][sel.stage].valid &&
                                  stage_i[q][sel.stage].info.is_mul))
                            else $error("pipe %0d operand %0d forwarded from an early multiply",
                                        p, k);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  backend_pkg::reg_idx_t [backend_pkg::NPIPE-1:0]    w_addr_i,
    input  backend_pkg::word_t    [backend_pkg::NPIPE-1:0]    w_data_i,
    input  backend_pkg::reg_idx_t [2*backend_pkg::NPIPE-1:0]  r_addr_i,
    output backend_pkg::word_t    [2*backend_pkg::NPIPE-1:0]  r_data_o
);

    backend_pkg::word_t regs [1:backend_pkg::NREG-1];  // r0 is not stored

    // higher port index written last, so it wins on the same address
    always_ff @(posedge clk) begin
        if (!rst_i) begin
            for (int w = 0; w < backend_pkg::NPIPE; w++) begin
                if (w_addr_i[w] != '0) begin
                    regs[w_addr_i[w]] <= w_data_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 2 * backend_pkg::NPIPE; r++) begin
            r_data_o[r] = '0;
            if (r_addr_i[r] != '0) begin
                r_data_o[r] = regs[r_addr_i[r]];
                // bypass the write landing this cycle
                for (int w = 0; w < backend_pkg::NPIPE; w++) begin
                    if (w_addr_i[w] == r_addr_i[r]) begin
                        r_data_o[r] = w_data_i[w];
                    end
                end
            end
        end
    end

    // last cycle's write is held, port 1 taking a shared address
    for (genvar r = 0; r < 2 * backend_pkg::NPIPE; r++) begin : g_hold_check
        a_write_held: assert property (@(posedge clk) disable iff (rst_i)
            ($past(!rst_i) && r_addr_i[r] != '0 &&
             (r_addr_i[r] == $past(w_addr_i[0]) || r_addr_i[r] == $past(w_addr_i[1])) &&
             w_addr_i[0] != r_addr_i[r] && w_addr_i[1] != r_addr_i[r])
            |-> r_data_o[r] == (r_addr_i[r] == $past(w_addr_i[1]) ? $past(w_data_i[1])
                                                                   : $past(w_data_i[0])))
            else $error("read port %0d lost the previous write", r);
    end

endmodule

`default_nettype wire

// ==== backend_pipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

module backend_pipeline #(
    parameter bit MAIN_PIPE = 1'b1   // main pipe carries the multiplier
) (
    input  logic                                             clk,
    input  logic                                             rst_i,
    input  logic                                             issue_i,
    input  backend_pkg::stage_t                              entry_i,
    output backend_pkg::stage_t [backend_pkg::NSTAGE-1:0]    stage_o,     // ex, m1, m2
    output backend_pkg::word_t  [backend_pkg::NSTAGE-1:0]    fwd_data_o,
    output backend_pkg::reg_idx_t                            w_addr_o,
    output backend_pkg::word_t                               w_data_o
);

    backend_pkg::stage_t ex_q;
    backend_pkg::stage_t m1_q;
    backend_pkg::stage_t m2_q;
    backend_pkg::stage_t ex_out;   // ex with alu result filled in
    backend_pkg::stage_t m1_out;   // m1 with product filled in
    backend_pkg::word_t  ex_res;

    // ex stage alu
    always_comb begin
        case (ex_q.info.opcode)
            backend_pkg::OP_ADD,
            backend_pkg::OP_ADDI: ex_res = ex_q.op_a + ex_q.op_b;
            backend_pkg::OP_SUB:  ex_res = ex_q.op_a - ex_q.op_b;
            backend_pkg::OP_AND:  ex_res = ex_q.op_a & ex_q.op_b;
            backend_pkg::OP_OR:   ex_res = ex_q.op_a | ex_q.op_b;
            backend_pkg::OP_XOR:  ex_res = ex_q.op_a ^ ex_q.op_b;
            default:              ex_res = '0;  // nop, or mul still in flight
        endcase
        ex_out        = ex_q;
        ex_out.result = ex_res;
    end

    if (MAIN_PIPE) begin : g_mul
        backend_pkg::word_t                    pp_low_q;   // a_lo * b_lo
        logic [backend_pkg::HALF-1:0]          pp_cross_q; // low half of cross terms
        logic [backend_pkg::HALF-1:0]          a_lo, a_hi, b_lo, b_hi;
        backend_pkg::word_t                    m1_prod;

        assign a_lo = ex_q.op_a[backend_pkg::HALF-1:0];
        assign a_hi = ex_q.op_a[backend_pkg::XLEN-1:backend_pkg::HALF];
        assign b_lo = ex_q.op_b[backend_pkg::HALF-1:0];
        assign b_hi = ex_q.op_b[backend_pkg::XLEN-1:backend_pkg::HALF];

        // partial products ex -> m1, summed in m1
        always_ff @(posedge clk) begin
            pp_low_q   <= {{backend_pkg::HALF{1'b0}}, a_lo} * {{backend_pkg::HALF{1'b0}}, b_lo};
            pp_cross_q <= a_hi * b_lo + a_lo * b_hi;
        end

        assign m1_prod = pp_low_q + {pp_cross_q, {backend_pkg::HALF{1'b0}}};

        always_comb begin
            m1_out = m1_q;
            if (m1_q.info.is_mul) begin
                m1_out.result = m1_prod;
            end
        end
    end else begin : g_no_mul
        assign m1_out = m1_q;  // alu result already in place
    end

    always_ff @(posedge clk) begin
        ex_q       <= entry_i;
        ex_q.valid <= issue_i;
        m1_q       <= ex_out;
        m2_q       <= m1_out;
        if (rst_i) begin
            ex_q.valid <= 1'b0;
            m1_q.valid <= 1'b0;
            m2_q.valid <= 1'b0;
        end
    end

    assign stage_o[0] = ex_out;
    assign stage_o[1] = m1_out;
    assign stage_o[2] = m2_q;

    assign fwd_data_o[0] = ex_res;        // straight from the alu
    assign fwd_data_o[1] = m1_out.result;
    assign fwd_data_o[2] = m2_q.result;

    assign w_addr_o = m2_q.valid ? m2_q.info.rd : '0;  // r0 means no write
    assign w_data_o = m2_q.result;

    // steering in issue must keep multiplies off the second pipe
    if (!MAIN_PIPE) begin : g_alu_only
        a_no_mul: assert property (@(posedge clk) disable iff (rst_i)
            issue_i |-> !entry_i.info.is_mul)
            else $error("multiply steered to the second pipe");
    end

endmodule

`default_nettype wire

// ==== backend.sv ====
`timescale 1ns/10ps
`default_nettype none

module backend (
    input  logic                           clk,
    input  logic                           rst_i,
    input  backend_pkg::inst_t   [1:0]     inst_i,
    input  logic                 [1:0]     inst_valid_i,
    output logic                 [1:0]     issue_num_o,      // 0, 1 or 2
    output logic                           backend_stall_o,
    output backend_pkg::commit_t [1:0]     commit_o          // index 0 is older
);

    backend_pkg::decode_info_t [1:0]                                         decode;
    logic [1:0]                                                              issue;
    logic                                                                    revert;
    backend_pkg::fwd_sel_t [backend_pkg::NPIPE-1:0][1:0]                     fwd_sel;
    backend_pkg::stage_t   [backend_pkg::NPIPE-1:0][backend_pkg::NSTAGE-1:0] stage;
    backend_pkg::word_t    [backend_pkg::NPIPE-1:0][backend_pkg::NSTAGE-1:0] fwd_bus;
    backend_pkg::reg_idx_t [backend_pkg::NPIPE-1:0]                          reg_w_addr;
    backend_pkg::word_t    [backend_pkg::NPIPE-1:0]                          reg_w_data;
    backend_pkg::reg_idx_t [2*backend_pkg::NPIPE-1:0]                        reg_r_addr;
    backend_pkg::word_t    [2*backend_pkg::NPIPE-1:0]                        reg_r_data;
    logic                                                                    m2_first;
    backend_pkg::commit_t  [1:0]                                             commit_d;

    function automatic backend_pkg::word_t fwd_mux(input backend_pkg::fwd_sel_t sel,
                                                   input backend_pkg::word_t rf_data);
        backend_pkg::word_t data;
        data = rf_data;
        for (int q = 0; q < backend_pkg::NPIPE; q++) begin
            if (sel.src[q]) data = fwd_bus[q][sel.stage];
        end
        return data;
    endfunction

    for (genvar s = 0; s < 2; s++) begin : g_slot
        decoder decoder_module (
            .inst_word_i (inst_i[s].word),
            .inst_valid_i(inst_valid_i[s]),
            .decode_o    (decode[s])
        );
    end

    issue issue_module (
        .decode_i    (decode),
        .inst_valid_i(inst_valid_i),
        .stage_i     (stage),
        .issue_o     (issue),
        .revert_o    (revert),
        .fwd_sel_o   (fwd_sel)
    );

    assign issue_num_o     = {issue[1], issue[0] & ~issue[1]};
    assign backend_stall_o = |(inst_valid_i & ~issue);

    reg_file reg_file_module (
        .clk     (clk),
        .rst_i   (rst_i),
        .w_addr_i(reg_w_addr),
        .w_data_i(reg_w_data),
        .r_addr_i(reg_r_addr),
        .r_data_o(reg_r_data)
    );

    for (genvar p = 0; p < backend_pkg::NPIPE; p++) begin : g_pipe
        logic                      slot;   // slot steered into this pipe
        backend_pkg::decode_info_t info;
        backend_pkg::stage_t       entry;

        assign slot                = (p != 0) ^ revert;
        assign info                = decode[slot];
        assign reg_r_addr[2*p]     = info.rs1;
        assign reg_r_addr[2*p + 1] = info.rs2;

        always_comb begin
            entry        = '0;
            entry.valid  = issue[slot];
            entry.older  = !slot;
            entry.pc     = inst_i[slot].pc;
            entry.info   = info;
            entry.op_a   = fwd_mux(fwd_sel[p][0], reg_r_data[2*p]);
            entry.op_b   = info.use_rs2 ? fwd_mux(fwd_sel[p][1], reg_r_data[2*p + 1])
                                        : info.imm;
        end

        backend_pipeline #(
            .MAIN_PIPE(p == 0)
        ) pipeline_module (
            .clk       (clk),
            .rst_i     (rst_i),
            .issue_i   (entry.valid),
            .entry_i   (entry),
            .stage_o   (stage[p]),
            .fwd_data_o(fwd_bus[p]),
            .w_addr_o  (reg_w_addr[p]),
            .w_data_o  (reg_w_data[p])
        );
    end

    // older m2 instruction goes out first
    assign m2_first = stage[1][backend_pkg::NSTAGE-1].valid &&
                      stage[1][backend_pkg::NSTAGE-1].older;

    always_comb begin
        backend_pkg::stage_t m2;
        for (int i = 0; i < 2; i++) begin
            m2 = stage[m2_first ^ (i != 0)][backend_pkg::NSTAGE-1];
            commit_d[i].valid  = m2.valid;
            commit_d[i].pc     = m2.pc;
            commit_d[i].w_reg  = m2.info.rd;
            commit_d[i].w_data = m2.result;
        end
    end

    always_ff @(posedge clk) begin
        commit_o <= commit_d;
        if (rst_i) begin
            commit_o[0].valid <= 1'b0;
            commit_o[1].valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== backend_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module backend_checker #(
    parameter int N_ENTRIES = 20
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [31:0]                trace_i [0:4*N_ENTRIES-1],  // pc, word, rd, data
    input  logic [1:0]                 inst_valid_i,
    input  logic [1:0]                 issue_num_i,
    input  logic                       stall_i,
    input  backend_pkg::commit_t [1:0] commit_i,
    output int                         commit_count_o,
    output int                         pass_count_o,
    output int                         error_count_o
);

    int n_commit = 0;  // next expected trace entry
    int n_pass = 0;
    int n_error = 0;

    assign commit_count_o = n_commit;
    assign pass_count_o   = n_pass;
    assign error_count_o  = n_error;

    task automatic check_commit(input backend_pkg::commit_t c);
        logic [31:0] exp_pc;
        logic [31:0] exp_rd;
        logic [31:0] exp_data;
        string       name;
        logic        ok;
        if (n_commit >= N_ENTRIES) begin
            $display("extra commit from pc %08h after the whole trace retired", c.pc);
            n_error++;
        end else begin
            exp_pc   = trace_i[4*n_commit];
            exp_rd   = trace_i[4*n_commit + 2];
            exp_data = trace_i[4*n_commit + 3];
            name     = $sformatf("commit %0d (pc %08h)", n_commit, exp_pc);
            ok = (c.pc == exp_pc) && (c.w_reg == exp_rd[4:0]) &&
                 (exp_rd == 32'd0 || c.w_data == exp_data);  // r0 data is dropped
            if (ok) begin
                $display("%s: r%0d = %08h ok", name, c.w_reg, c.w_data);
                n_pass++;
            end else begin
                $display("** Error %s: expected pc %08h r%0d = %08h, actual pc %08h r%0d = %08h",
                         name, exp_pc, exp_rd, exp_data, c.pc, c.w_reg, c.w_data);
                n_error++;
            end
            n_commit++;
        end
    endtask

    // issue count and stall must agree with the valid slots
    task automatic check_issue();
        int want;
        want = int'(inst_valid_i[0]) + int'(inst_valid_i[1]);
        if (int'(issue_num_i) > want) begin
            $display("** Error issue count: expected at most %0d, actual %0d",
                     want, issue_num_i);
            n_error++;
        end
        if (stall_i !== (int'(issue_num_i) < want)) begin
            $display("** Error stall: expected %b, actual %b",
                     int'(issue_num_i) < want, stall_i);
            n_error++;
        end
    endtask

    // mid-cycle, when everything has settled
    always @(negedge clk) begin
        if (rst_i) begin
            if (commit_i[0].valid !== 1'b0 || commit_i[1].valid !== 1'b0) begin
                $display("a commit showed up while reset was high");
                n_error++;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (commit_i[i].valid === 1'b1) begin
                    check_commit(commit_i[i]);  // index 0 is the older one
                end
            end
            check_issue();
        end
    end

endmodule

`default_nettype wire

// ==== tb_backend.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_backend;

    localparam int N_ENTRIES = 20;
    localparam int CLK_HALF = 50;
    localparam int SEED = 73;
    localparam int WATCHDOG_CYCLES = N_ENTRIES * 6 + 40;

    logic                       clk;
    logic                       rst;
    backend_pkg::inst_t   [1:0] inst;
    logic                 [1:0] inst_valid;
    logic                 [1:0] issue_num;
    logic                       backend_stall;
    backend_pkg::commit_t [1:0] commit;
    logic [31:0]                trace [0:4*N_ENTRIES-1];
    int                         commit_count;
    int                         pass_count;
    int                         error_count;
    int                         next_idx;  // oldest entry not yet issued
    int                         gap;       // bubble cycles left

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    backend backend_inst (
        .clk            (clk),
        .rst_i          (rst),
        .inst_i         (inst),
        .inst_valid_i   (inst_valid),
        .issue_num_o    (issue_num),
        .backend_stall_o(backend_stall),
        .commit_o       (commit)
    );

    backend_checker #(
        .N_ENTRIES(N_ENTRIES)
    ) checker_inst (
        .clk           (clk),
        .rst_i         (rst),
        .trace_i       (trace),
        .inst_valid_i  (inst_valid),
        .issue_num_i   (issue_num),
        .stall_i       (backend_stall),
        .commit_i      (commit),
        .commit_count_o(commit_count),
        .pass_count_o  (pass_count),
        .error_count_o (error_count)
    );

    // present the two oldest unissued entries, or nothing in a bubble
    task automatic drive_window(input logic hold);
        inst       = '0;
        inst_valid = 2'b00;
        if (!hold) begin
            for (int s = 0; s < 2; s++) begin
                if (next_idx + s < N_ENTRIES) begin
                    inst[s].pc       = trace[4*(next_idx + s)];
                    inst[s].word.raw = trace[4*(next_idx + s) + 1];
                    inst_valid[s]    = 1'b1;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        $readmemh("backend_trace.txt", trace);
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 2'b00;
        next_idx   = 0;
        gap        = 0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        while (next_idx < N_ENTRIES) begin
            drive_window(gap > 0);
            @(negedge clk);
            if (gap > 0) begin
                gap--;
            end else begin
                next_idx += int'(issue_num);  // consumed at the next edge
                if (issue_num != 2'd0 && $urandom % 4 == 0) begin
                    gap = $urandom % 3;
                end
            end
            @(posedge clk);
            #1;
        end
        drive_window(1'b1);
        wait (commit_count == N_ENTRIES);
        repeat (6) @(negedge clk);  // room for a stray extra commit
        $display("%0d tests, %0d passed, %0d errors", N_ENTRIES, pass_count, error_count);
        if (error_count == 0 && pass_count == N_ENTRIES) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: %0d of %0d expected commits never arrived",
                 N_ENTRIES - commit_count, N_ENTRIES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== backend_trace.txt ====
// one instruction per line: pc, instruction word, expected rd, expected rd value
// rd 00 means the write is dropped, so its value is not compared
00000000 60800005 01 00000005
00000004 6103FFFD 02 FFFFFFFD
00000008 11844000 03 00000002
0000000C 62000100 04 00000100
00000010 22906000 05 000000FE
00000014 53142000 06 000000FB
00000018 43848000 07 00000105
0000001C 3418E000 08 00000001
00000020 74944000 09 FFFFFD06
00000024 15242000 0A FFFFFD0B
00000028 65800007 0B 00000007
0000002C 762D6000 0C 00000031
00000030 10048000 00 00000000
00000034 10818000 01 00000031
00000038 5180E000 03 00000105
0000003C 72046000 04 000031F5
00000040 72884000 05 00000009
00000044 1310A000 06 000031FE
00000048 639BFFF0 07 000031EE
0000004C 141D2000 08 00002EF4

// ==== project.f ====
backend_pkg.sv
decoder.sv
issue.sv
reg_file.sv
backend_pipeline.sv
backend.sv
backend_checker.sv
tb_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_backend
./obj_dir/Vtb_backend | tee sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
